// ==== dtag_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtag_bank
  import dtag_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              read_clk_en,
  input  wire              read_en,
  input  wire [line_w-1:0] read_addr,
  input  bank_op_e         op,
  input  wire              wr_exclusive,
  output logic             init_done,
  output logic             hit,
  output logic             valid,
  output logic             exclusive,
  output logic             err,
  output logic [line_w-1:0] old_line
);

  logic                init;
  logic [set_bits-1:0] init_cnt;
  logic [line_w-1:0]   addr_reg;
  logic                en_reg;
  logic                bad_parity;
  entry_t              rd_entry;
  entry_t              next_entry;
  entry_t              wr_entry;
  logic [set_bits-1:0] wr_addr;
  logic                wr_en;

  // clearing sweep, one set per cycle after reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      init     <= 1'b1;
      init_cnt <= '0;
    end else if (init) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == set_bits'(sets - 1)) begin
        init <= 1'b0;
      end
    end
  end

  assign init_done = ~init;

  // lookups are dropped until the sweep is over.
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_reg <= '0;
      en_reg   <= 1'b0;
    end else if (read_clk_en) begin
      addr_reg <= read_addr;
      en_reg   <= read_en & ~init;
    end else begin
      en_reg <= 1'b0;
    end
  end

  dtag_ram u_ram (
    .clk        (clk),
    .rst        (rst),
    .read_clk_en(read_clk_en),
    .read_addr  (read_addr[set_bits-1:0]),
    .read_data  (rd_entry),
    .write_addr (wr_addr),
    .write_data (wr_entry),
    .write_wen  (wr_en)
  );

  // an entry with bad parity counts as invalid and not exclusive.
  assign bad_parity = ^rd_entry;
  assign err        = en_reg & bad_parity;
  assign valid      = rd_entry.valid & ~bad_parity;
  assign exclusive  = rd_entry.exclusive & ~bad_parity;

  assign hit = (rd_entry.tag == addr_reg[line_w-1:set_bits]) && valid && en_reg;

  // line that currently occupies the set.
  assign old_line = {rd_entry.tag, addr_reg[set_bits-1:0]};

  always_comb begin
    next_entry           = rd_entry;
    next_entry.valid     = valid;
    next_entry.recent    = hit;
    next_entry.exclusive = exclusive;
    case (op)
      op_invl: begin
        next_entry.valid = valid & ~hit;
      end
      op_fill: begin
        next_entry.tag       = addr_reg[line_w-1:set_bits];
        next_entry.valid     = 1'b1;
        next_entry.recent    = 1'b0;
        next_entry.exclusive = wr_exclusive;
      end
      default: begin
      end
    endcase
    next_entry.parity = entry_parity(next_entry);
  end

  // the sweep owns the write port while it runs.
  assign wr_addr  = init ? init_cnt : addr_reg[set_bits-1:0];
  assign wr_entry = init ? entry_t'('0) : next_entry;
  assign wr_en    = init | (op != op_none);

  // the combiner must not request a write while this bank is still clearing.
  a_no_op_in_init: assert property (@(posedge clk) disable iff (rst)
    init |-> op == op_none);

  // a fill is only ever driven for a lookup this bank has registered.
  a_fill_needs_lookup: assert property (@(posedge clk) disable iff (rst)
    op == op_fill |-> en_reg);

endmodule

`default_nettype wire

// ==== dtag_combine.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtag_combine
  import dtag_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  wire               read_clk_en,
  input  wire               read_en,
  input  wire               read_odd,
  input  wire               read_split,
  input  wire               read_invl,
  input  wire               fill_en,
  input  wire               fill_exclusive,
  input  wire               hit_e,
  input  wire               hit_o,
  input  wire               valid_e,
  input  wire               valid_o,
  input  wire               excl_in_e,
  input  wire               excl_in_o,
  input  wire               err_in_e,
  input  wire               err_in_o,
  input  wire [line_w-1:0]  old_line_e,
  input  wire [line_w-1:0]  old_line_o,
  output bank_op_e          op_even,
  output bank_op_e          op_odd,
  output logic              wr_exclusive,
  output logic              hit_even,
  output logic              hit_odd,
  output logic              hit_high_even,
  output logic              hit_high_odd,
  output logic              hit_low_even,
  output logic              hit_low_odd,
  output logic              excl_even,
  output logic              excl_odd,
  output logic              err_even,
  output logic              err_odd,
  output logic [line_w-1:0] wb_addr,
  output logic              wb_valid
);

  logic     en_reg;
  logic     odd_reg;
  logic     split_reg;
  logic     invl_reg;
  logic     fill_reg;
  bank_op_e sel_op;

  // same enable rule as the banks; a fill only counts with a lookup.
  always_ff @(posedge clk) begin
    if (rst) begin
      en_reg       <= 1'b0;
      odd_reg      <= 1'b0;
      split_reg    <= 1'b0;
      invl_reg     <= 1'b0;
      fill_reg     <= 1'b0;
      wr_exclusive <= 1'b0;
    end else if (read_clk_en) begin
      en_reg       <= read_en;
      odd_reg      <= read_odd;
      split_reg    <= read_split;
      invl_reg     <= read_invl;
      fill_reg     <= fill_en & read_en;
      wr_exclusive <= fill_exclusive;
    end else begin
      en_reg   <= 1'b0;
      fill_reg <= 1'b0;
    end
  end

  assign hit_even = hit_e;
  assign hit_odd  = hit_o;

  // high half sits in the selected bank.
  assign hit_high_even = ~odd_reg & hit_e;
  assign hit_high_odd  = odd_reg & hit_o;

  // a split access takes its low half from the other bank.
  assign hit_low_even = split_reg ? (odd_reg & hit_e) : hit_high_even;
  assign hit_low_odd  = split_reg ? (~odd_reg & hit_o) : hit_high_odd;

  assign excl_even = excl_in_e;
  assign excl_odd  = excl_in_o;
  assign err_even  = err_in_e;
  assign err_odd   = err_in_o;

  // evicted line on a fill.
  assign wb_addr  = fill_reg ? (odd_reg ? old_line_o : old_line_e) : '0;
  assign wb_valid = fill_reg & (odd_reg ? valid_o : valid_e);

  always_comb begin
    if (fill_reg) begin
      sel_op = op_fill;
    end else if (invl_reg && en_reg) begin
      sel_op = op_invl;
    end else if (en_reg) begin
      sel_op = op_touch;
    end else begin
      sel_op = op_none;
    end
  end

  assign op_even = odd_reg ? op_none : sel_op;
  assign op_odd  = odd_reg ? sel_op : op_none;

  // a bank only reports a hit for a lookup this stage has registered too.
  a_hit_needs_lookup: assert property (@(posedge clk) disable iff (rst)
    (hit_e || hit_o) |-> en_reg);

endmodule

`default_nettype wire

// ==== dtag_pkg.sv ====
`default_nettype none

package dtag_pkg;

  // line address is the 44-bit physical address without the 8-bit offset.
  localparam int line_w = 36;

  // direct-mapped index into one bank.
  localparam int set_bits = 6;
  localparam int sets = 1 << set_bits;

  // stored tag is what is left of the line address above the index.
  localparam int tag_w = line_w - set_bits;

  // tag plus valid, recent, exclusive and parity.
  localparam int entry_w = tag_w + 4;

  // tag entry as it sits in the ram.
  // parity makes the xor over the whole entry zero.
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic             valid;
    logic             recent;
    logic             exclusive;
    logic             parity;
  } entry_t;

  // write applied to a bank entry at the end of the result cycle.
  typedef enum logic [1:0] {
    op_none,
    op_touch,
    op_invl,
    op_fill
  } bank_op_e;

  // even parity over everything except the parity bit itself.
  function automatic logic entry_parity(entry_t e);
    return ^{e.tag, e.valid, e.recent, e.exclusive};
  endfunction

endpackage

`default_nettype wire

// ==== dtag_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtag_ram
  import dtag_pkg::*;
(
  input  wire                clk,
  input  wire                rst,
  input  wire                read_clk_en,
  input  wire [set_bits-1:0] read_addr,
  output entry_t             read_data,
  input  wire [set_bits-1:0] write_addr,
  input  entry_t             write_data,
  input  wire                write_wen
);

  logic [entry_w-1:0]  mem [sets];
  logic [set_bits-1:0] read_addr_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      read_addr_reg <= '0;
    end else if (read_clk_en) begin
      read_addr_reg <= read_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_wen) begin
      mem[write_addr] <= write_data;
    end
  end

  // array read from the held address, so a write shows up next cycle.
  assign read_data = entry_t'(mem[read_addr_reg]);

endmodule

`default_nettype wire

// ==== dtag_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module dtag_top
  import dtag_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  input  wire               read_clk_en,
  input  wire               read_en,
  input  wire [line_w-1:0]  read_addr_even,
  input  wire [line_w-1:0]  read_addr_odd,
  input  wire               read_odd,
  input  wire               read_split,
  input  wire               read_invl,
  input  wire               fill_en,
  input  wire               fill_exclusive,
  output logic              init_done,
  output logic              hit_even,
  output logic              hit_odd,
  output logic              hit_high_even,
  output logic              hit_high_odd,
  output logic              hit_low_even,
  output logic              hit_low_odd,
  output logic              excl_even,
  output logic              excl_odd,
  output logic              err_even,
  output logic              err_odd,
  output logic [line_w-1:0] wb_addr,
  output logic              wb_valid
);

  bank_op_e          op_even;
  bank_op_e          op_odd;
  logic              wr_exclusive;
  logic              hit_e;
  logic              hit_o;
  logic              valid_e;
  logic              valid_o;
  logic              excl_e;
  logic              excl_o;
  logic              err_e;
  logic              err_o;
  logic [line_w-1:0] old_line_e;
  logic [line_w-1:0] old_line_o;

  // both sweeps start together so the even bank speaks for both.
  dtag_bank u_bank_even (
    .clk         (clk),
    .rst         (rst),
    .read_clk_en (read_clk_en),
    .read_en     (read_en),
    .read_addr   (read_addr_even),
    .op          (op_even),
    .wr_exclusive(wr_exclusive),
    .init_done   (init_done),
    .hit         (hit_e),
    .valid       (valid_e),
    .exclusive   (excl_e),
    .err         (err_e),
    .old_line    (old_line_e)
  );

  dtag_bank u_bank_odd (
    .clk         (clk),
    .rst         (rst),
    .read_clk_en (read_clk_en),
    .read_en     (read_en),
    .read_addr   (read_addr_odd),
    .op          (op_odd),
    .wr_exclusive(wr_exclusive),
    .init_done   (),
    .hit         (hit_o),
    .valid       (valid_o),
    .exclusive   (excl_o),
    .err         (err_o),
    .old_line    (old_line_o)
  );

  dtag_combine u_combine (
    .clk           (clk),
    .rst           (rst),
    .read_clk_en   (read_clk_en),
    .read_en       (read_en),
    .read_odd      (read_odd),
    .read_split    (read_split),
    .read_invl     (read_invl),
    .fill_en       (fill_en),
    .fill_exclusive(fill_exclusive),
    .hit_e         (hit_e),
    .hit_o         (hit_o),
    .valid_e       (valid_e),
    .valid_o       (valid_o),
    .excl_in_e     (excl_e),
    .excl_in_o     (excl_o),
    .err_in_e      (err_e),
    .err_in_o      (err_o),
    .old_line_e    (old_line_e),
    .old_line_o    (old_line_o),
    .op_even       (op_even),
    .op_odd        (op_odd),
    .wr_exclusive  (wr_exclusive),
    .hit_even      (hit_even),
    .hit_odd       (hit_odd),
    .hit_high_even (hit_high_even),
    .hit_high_odd  (hit_high_odd),
    .hit_low_even  (hit_low_even),
    .hit_low_odd   (hit_low_odd),
    .excl_even     (excl_even),
    .excl_odd      (excl_odd),
    .err_even      (err_even),
    .err_odd       (err_odd),
    .wb_addr       (wb_addr),
    .wb_valid      (wb_valid)
  );

endmodule

`default_nettype wire

// ==== list.f ====
dtag_pkg.sv
dtag_ram.sv
dtag_bank.sv
dtag_combine.sv
dtag_top.sv
tb_dtag.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_dtag -f list.f -o tb_dtag &&
./obj_dir/tb_dtag ||
{ echo "simulation run returned an error"; exit 1; }

// ==== tb_dtag.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dtag
  import dtag_pkg::*;
();

  localparam int random_cycles = 600;
  localparam int cycle_limit = 5 + sets + 4 * random_cycles + 100;

  // one lookup as seen on the inputs in its issue cycle.
  typedef struct packed {
    logic              issue;
    logic [line_w-1:0] addr_e;
    logic [line_w-1:0] addr_o;
    logic              odd;
    logic              split;
    logic              invl;
    logic              fill;
    logic              fexcl;
  } stim_t;

  typedef struct packed {
    logic              hit_even;
    logic              hit_odd;
    logic              high_even;
    logic              high_odd;
    logic              low_even;
    logic              low_odd;
    logic [line_w-1:0] wb_addr;
    logic              wb_valid;
  } result_t;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              read_clk_en;
  logic              read_en;
  logic [line_w-1:0] read_addr_even;
  logic [line_w-1:0] read_addr_odd;
  logic              read_odd;
  logic              read_split;
  logic              read_invl;
  logic              fill_en;
  logic              fill_exclusive;
  logic              init_done;
  logic              hit_even;
  logic              hit_odd;
  logic              hit_high_even;
  logic              hit_high_odd;
  logic              hit_low_even;
  logic              hit_low_odd;
  logic              excl_even;
  logic              excl_odd;
  logic              err_even;
  logic              err_odd;
  logic [line_w-1:0] wb_addr;
  logic              wb_valid;

  entry_t            model_even [sets];
  entry_t            model_odd [sets];
  stim_t             pend;
  entry_t            ent_e;
  entry_t            ent_o;
  result_t           want;
  logic [31:0]       rng;
  logic [line_w-1:0] line_a;
  logic [line_w-1:0] line_a2;
  logic [line_w-1:0] line_b;
  int                hit_count;
  int                sweep;
  int                cycles = 0;

  dtag_top u_dtag_top (
    .clk           (clk),
    .rst           (rst),
    .read_clk_en   (read_clk_en),
    .read_en       (read_en),
    .read_addr_even(read_addr_even),
    .read_addr_odd (read_addr_odd),
    .read_odd      (read_odd),
    .read_split    (read_split),
    .read_invl     (read_invl),
    .fill_en       (fill_en),
    .fill_exclusive(fill_exclusive),
    .init_done     (init_done),
    .hit_even      (hit_even),
    .hit_odd       (hit_odd),
    .hit_high_even (hit_high_even),
    .hit_high_odd  (hit_high_odd),
    .hit_low_even  (hit_low_even),
    .hit_low_odd   (hit_low_odd),
    .excl_even     (excl_even),
    .excl_odd      (excl_odd),
    .err_even      (err_even),
    .err_odd       (err_odd),
    .wb_addr       (wb_addr),
    .wb_valid      (wb_valid)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // small tag pool so that random lookups hit often.
  function automatic logic [tag_w-1:0] tag_pick(input logic [1:0] k);
    case (k)
      2'd0: return 30'h2bc_d0f1;
      2'd1: return 30'h012_3457;
      2'd2: return 30'h0a5_5a5a;
      default: return 30'h3ff_0003;
    endcase
  endfunction

  // four tags over eight indexes spread across the bank.
  function automatic logic [line_w-1:0] pick_line(input logic [4:0] r);
    return {tag_pick(r[1:0]), r[4:2], r[4:2]};
  endfunction

  // expected outputs one cycle after issue from the entries the lookup reads.
  function automatic result_t expect_result(input stim_t s, input entry_t ee, input entry_t eo);
    result_t r;
    r = '0;
    if (s.issue) begin
      r.hit_even  = ee.valid && (ee.tag == s.addr_e[line_w-1:set_bits]);
      r.hit_odd   = eo.valid && (eo.tag == s.addr_o[line_w-1:set_bits]);
      r.high_even = !s.odd && r.hit_even;
      r.high_odd  = s.odd && r.hit_odd;
      r.low_even  = s.split ? (s.odd && r.hit_even) : r.high_even;
      r.low_odd   = s.split ? (!s.odd && r.hit_odd) : r.high_odd;
      if (s.fill) begin
        r.wb_valid = s.odd ? eo.valid : ee.valid;
        r.wb_addr  = s.odd ? {eo.tag, s.addr_o[set_bits-1:0]} : {ee.tag, s.addr_e[set_bits-1:0]};
      end
    end
    return r;
  endfunction

  // entry written back into the selected bank.
  function automatic entry_t next_entry(input stim_t s, input entry_t e, input logic hit,
                                        input logic [line_w-1:0] addr);
    entry_t n;
    n = e;
    n.recent = hit;
    if (s.fill) begin
      n.tag       = addr[line_w-1:set_bits];
      n.valid     = 1'b1;
      n.recent    = 1'b0;
      n.exclusive = s.fexcl;
    end else if (s.invl && hit) begin
      n.valid = 1'b0;
    end
    n.parity = ^{n.tag, n.valid, n.recent, n.exclusive};
    return n;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_error(input string msg);
    stop_run($sformatf("** Error at %0t: %s", $time, msg));
  endtask

  task automatic check_hits(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", name, got, exp));
    end
  endtask

  task automatic check_line(input string name, input logic [line_w-1:0] got,
                            input logic [line_w-1:0] exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_entry_flags(input string name, input logic got_excl, input logic got_valid,
                                   input entry_t exp, input logic valid_seen);
    if (got_excl !== exp.exclusive) begin
      report_error($sformatf("%s exclusive is %b, expected %b", name, got_excl, exp.exclusive));
    end
    if (valid_seen && got_valid !== exp.valid) begin
      report_error($sformatf("%s evicted valid is %b, expected %b", name, got_valid, exp.valid));
    end
  endtask

  task automatic drive_inputs(input logic ce, input logic en, input logic [line_w-1:0] ae,
                              input logic [line_w-1:0] ao, input logic odd, input logic split,
                              input logic invl, input logic fill, input logic fexcl);
    @(posedge clk);
    read_clk_en    <= ce;
    read_en        <= en;
    read_addr_even <= ae;
    read_addr_odd  <= ao;
    read_odd       <= odd;
    read_split     <= split;
    read_invl      <= invl;
    fill_en        <= fill;
    fill_exclusive <= fexcl;
  endtask

  task automatic lookup(input logic [line_w-1:0] ae, input logic [line_w-1:0] ao,
                        input logic odd, input logic split, input logic invl,
                        input logic fill, input logic fexcl);
    drive_inputs(1'b1, 1'b1, ae, ao, odd, split, invl, fill, fexcl);
  endtask

  task automatic idle_cycle();
    drive_inputs(1'b1, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      stop_run("timeout, the run did not finish within the cycle limit");
    end
  end

  // compares the results of last cycle's inputs and then takes this cycle's inputs.
  always @(negedge clk) begin
    if (rst) begin
      pend = '0;
    end else begin
      ent_e = model_even[pend.addr_e[set_bits-1:0]];
      ent_o = model_odd[pend.addr_o[set_bits-1:0]];
      want  = expect_result(pend, ent_e, ent_o);
      check_hits("hit_even", hit_even, want.hit_even);
      check_hits("hit_odd", hit_odd, want.hit_odd);
      check_hits("hit_high_even", hit_high_even, want.high_even);
      check_hits("hit_high_odd", hit_high_odd, want.high_odd);
      check_hits("hit_low_even", hit_low_even, want.low_even);
      check_hits("hit_low_odd", hit_low_odd, want.low_odd);
      check_hits("wb_valid", wb_valid, want.wb_valid);
      check_hits("err_even", err_even, 1'b0);
      check_hits("err_odd", err_odd, 1'b0);
      check_line("wb_addr", wb_addr, want.wb_addr);
      if (pend.issue) begin
        check_entry_flags("even bank", excl_even, wb_valid, ent_e, pend.fill && !pend.odd);
        check_entry_flags("odd bank", excl_odd, wb_valid, ent_o, pend.fill && pend.odd);
        if (want.hit_even || want.hit_odd) begin
          hit_count++;
        end
        if (pend.odd) begin
          model_odd[pend.addr_o[set_bits-1:0]] = next_entry(pend, ent_o, want.hit_odd,
                                                            pend.addr_o);
        end else begin
          model_even[pend.addr_e[set_bits-1:0]] = next_entry(pend, ent_e, want.hit_even,
                                                             pend.addr_e);
        end
      end
      pend.issue  = read_clk_en && read_en && init_done;
      pend.addr_e = read_addr_even;
      pend.addr_o = read_addr_odd;
      pend.odd    = read_odd;
      pend.split  = read_split;
      pend.invl   = read_invl;
      pend.fill   = fill_en;
      pend.fexcl  = fill_exclusive;
    end
  end

  initial begin
    read_clk_en    = 1'b0;
    read_en        = 1'b0;
    read_addr_even = '0;
    read_addr_odd  = '0;
    read_odd       = 1'b0;
    read_split     = 1'b0;
    read_invl      = 1'b0;
    fill_en        = 1'b0;
    fill_exclusive = 1'b0;
    rng            = 32'd29;
    hit_count      = 0;
    for (int i = 0; i < sets; i++) begin
      model_even[i] = '0;
      model_odd[i]  = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // the sweep clears one set per cycle.
    sweep = 0;
    @(negedge clk);
    while (!init_done) begin
      sweep++;
      @(negedge clk);
    end
    if (sweep != sets) begin
      report_error($sformatf("init_done after %0d cycles, expected %0d", sweep, sets));
    end

    line_a  = {tag_pick(2'd0), 6'd5};
    line_a2 = {tag_pick(2'd1), 6'd5};
    line_b  = {tag_pick(2'd2), 6'd5};
    lookup(line_a, line_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    lookup(line_a, line_b, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);

    // fill then read back in the very next cycle.
    lookup(line_a, line_b, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    lookup(line_a, line_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle_cycle();
    @(negedge clk);
    check_hits("hit_high_even after fill", hit_high_even, 1'b1);
    check_hits("excl_even after fill", excl_even, 1'b1);

    lookup(line_a2, line_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    lookup(line_a2, line_b, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    idle_cycle();
    @(negedge clk);
    check_hits("wb_valid on eviction", wb_valid, 1'b1);
    check_line("wb_addr on eviction", wb_addr, line_a);

    // low half of a split access lives in the odd bank.
    lookup(line_a2, line_b, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    lookup(line_a2, line_b, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    idle_cycle();
    @(negedge clk);
    check_hits("hit_low_odd on split", hit_low_odd, 1'b1);
    check_hits("hit_low_even on split", hit_low_even, 1'b0);

    // invalidate and then try a stalled fill of line_a that must not land.
    lookup(line_a2, line_b, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    drive_inputs(1'b0, 1'b1, line_a, line_b, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    lookup(line_a2, line_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle_cycle();
    @(negedge clk);
    check_hits("hit_even after invalidate", hit_even, 1'b0);
    lookup(line_a, line_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    idle_cycle();
    @(negedge clk);
    check_hits("hit_even after stalled fill", hit_even, 1'b0);

    for (int i = 0; i < random_cycles; i++) begin
      rng = xorshift(rng);
      drive_inputs(rng[2:0] != 3'd0, rng[3] | rng[22], pick_line(rng[8:4]), pick_line(rng[13:9]),
                   rng[14], rng[15], rng[17:16] == 2'd0, rng[20:18] == 3'd0, rng[21]);
    end
    idle_cycle();
    idle_cycle();
    @(negedge clk);
    @(posedge clk);
    if (hit_count == 0) begin
      stop_run("no lookup ever hit, the stimulus did not reach the tag compare");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
